//--- logic/spi_pkg.sv
// SPI register slave
// Shared types and constants
package spi_pkg;

    // Basic widths
    typedef logic [7:0] byte_t;      // One data byte
    typedef logic [4:0] reg_addr_t;  // Register address, 32 entries
    typedef logic [3:0] bit_cnt_t;   // Bits seen in current byte, 0..8
    typedef logic [4:0] byte_cnt_t;  // Data bytes still expected in frame

    // Bank size and synchronizer depth
    localparam int REG_COUNT   = 32;
    localparam int SYNC_STAGES = 2;

    // Sent on MISO while command and length bytes are shifted
    localparam byte_t IDLE_PATTERN = 8'hA5;

    // Command byte layout, MSB first
    typedef struct packed {
        logic      long_fmt;  // 1 = length byte follows
        logic      read;      // 1 = master reads the bank
        logic      rsvd;      // Ignored
        reg_addr_t addr;      // Start address
    } spi_cmd_t;

    // Write strobe into the register bank
    typedef struct packed {
        logic      en;    // One-cycle write enable
        reg_addr_t addr;  // Target register
        byte_t     data;  // Value to store
    } reg_wr_t;

    // Frame controller states
    typedef enum logic [2:0] {
        SPI_IDLE,   // Waiting for SS fall
        SPI_LOAD,   // Transmit byte goes into the shifter
        SPI_TRANS,  // Byte is being shifted
        SPI_SAVE,   // Parse the byte or issue the write
        SPI_BACK,   // Turnaround before the next byte
        SPI_RST     // Frame end, flag result
    } spi_state_e;

endpackage

//--- logic/sclk_edge_detect.sv
// SPI input synchronizer and edge detector
`timescale 1ns/10ps

module sclk_edge_detect import spi_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic sclk,        // Raw SPI clock
    input  logic ss,          // Raw slave select, active low
    input  logic mosi,        // Raw master data
    output logic sclk_rise,   // One-cycle pulse per SCLK rise
    output logic sclk_fall,   // One-cycle pulse per SCLK fall
    output logic ss_fall,     // Frame start pulse
    output logic ss_rise,     // Frame end pulse
    output logic ss_level,    // Synchronized SS, aligned with the pulses
    output logic mosi_sync    // MOSI delayed to match the edge pulses
);

    logic [SYNC_STAGES-1:0] sclk_meta;  // Synchronizer chains, newest bit at 0
    logic [SYNC_STAGES-1:0] ss_meta;
    logic [SYNC_STAGES-1:0] mosi_meta;
    logic                   sclk_d;     // Previous synchronized SCLK

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_meta <= '0;  // SCLK idles low in mode 1
            ss_meta   <= '1;  // Slave not selected
            mosi_meta <= '0;
            sclk_d    <= 1'b0;
            ss_level  <= 1'b1;
            mosi_sync <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
            ss_fall   <= 1'b0;
            ss_rise   <= 1'b0;
        end else begin
            sclk_meta <= {sclk_meta[SYNC_STAGES-2:0], sclk};
            ss_meta   <= {ss_meta[SYNC_STAGES-2:0], ss};
            mosi_meta <= {mosi_meta[SYNC_STAGES-2:0], mosi};

            // Third stage, compare against the delayed copy
            sclk_d    <= sclk_meta[SYNC_STAGES-1];
            sclk_rise <= sclk_meta[SYNC_STAGES-1] & ~sclk_d;
            sclk_fall <= ~sclk_meta[SYNC_STAGES-1] & sclk_d;

            ss_level  <= ss_meta[SYNC_STAGES-1];
            ss_fall   <= ~ss_meta[SYNC_STAGES-1] & ss_level;
            ss_rise   <= ss_meta[SYNC_STAGES-1] & ~ss_level;

            mosi_sync <= mosi_meta[SYNC_STAGES-1];  // Same 3-cycle latency
        end
    end

endmodule

//--- logic/spi_shift_reg.sv
// SPI byte shifter, mode 1
`timescale 1ns/10ps

module spi_shift_reg import spi_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  load,       // Take tx_byte, restart bit count
    input  byte_t tx_byte,
    input  logic  sclk_rise,  // Launch edge in mode 1
    input  logic  sclk_fall,  // Capture edge in mode 1
    input  logic  mosi,
    output logic  miso,
    output byte_t rx_byte,
    output logic  byte_done   // Pulse after the 8th capture
);

    // Count at which the last bit of a byte is captured
    localparam bit_cnt_t LAST_BIT = bit_cnt_t'($bits(byte_t) - 1);

    byte_t    tx_sr;    // Outgoing bits, MSB first
    byte_t    rx_sr;    // Incoming bits, MSB first
    bit_cnt_t bit_cnt;

    assign rx_byte = rx_sr;  // Valid from byte_done on until the next fall

    // Data path
    always_ff @(posedge clk) begin
        if (load) begin
            tx_sr <= tx_byte;
        end else if (sclk_rise) begin
            tx_sr <= {tx_sr[6:0], 1'b0};
        end

        if (sclk_fall) begin
            rx_sr <= {rx_sr[6:0], mosi};
        end
    end

    // Control and output pin
    always_ff @(posedge clk) begin
        if (rst) begin
            miso      <= 1'b0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            if (sclk_rise) begin
                miso <= tx_sr[7];  // MSB goes out first
            end

            if (load) begin
                bit_cnt <= '0;
            end else if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            // Count reaches 8 on this fall
            byte_done <= sclk_fall && (bit_cnt == LAST_BIT);
        end
    end

endmodule

//--- logic/spi_comm.sv
// SPI frame controller
// Command parsing, byte counting and register access
`timescale 1ns/10ps

module spi_comm import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ss_fall,
    input  logic      ss_rise,
    input  logic      ss_level,
    input  logic      byte_done,
    input  byte_t     rx_byte,
    output logic      load,         // Shifter load strobe
    output byte_t     tx_byte,      // Next byte for MISO
    output reg_wr_t   spi_wr,       // Bank write strobe
    output reg_addr_t spi_rd_addr,
    input  byte_t     spi_rd_data,  // Combinational bank read
    output logic      err,          // Last frame aborted
    output logic      busy,
    output logic      frame_done    // Last frame completed
);

    spi_state_e state;
    spi_state_e state_nxt;

    spi_cmd_t  cmd;           // Command of the current frame
    spi_cmd_t  rx_cmd;        // Received byte seen as a command
    reg_addr_t run_addr;      // Address of the next data byte
    byte_cnt_t remaining;     // Data bytes still announced
    logic      cmd_done;      // Command byte parsed
    logic      in_data;       // Length parsed too, now in data phase
    logic      frame_active;  // Set between SS fall and frame end
    logic      frame_complete;
    logic      data_valid;    // Current data byte is within the count

    assign rx_cmd         = spi_cmd_t'(rx_byte);
    assign data_valid     = in_data && (remaining != '0);
    assign frame_complete = in_data && (remaining == '0);

    assign load        = (state == SPI_LOAD);
    assign busy        = (state != SPI_IDLE);
    assign spi_rd_addr = run_addr;

    // Write strobe only during SAVE of a counted data byte
    always_comb begin
        spi_wr.en   = (state == SPI_SAVE) && data_valid && !cmd.read;
        spi_wr.addr = run_addr;
        spi_wr.data = rx_byte;
    end

    // Transmit byte, sampled by the shifter in LOAD
    always_comb begin
        if (frame_complete) begin
            tx_byte = '0;  // Count used up
        end else if (in_data && cmd.read) begin
            tx_byte = spi_rd_data;
        end else begin
            tx_byte = IDLE_PATTERN;  // Command, length or write data
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            SPI_IDLE: begin
                if (ss_fall) begin
                    state_nxt = SPI_LOAD;
                end
            end
            SPI_LOAD:  state_nxt = SPI_TRANS;
            SPI_TRANS: begin
                if (byte_done) begin
                    state_nxt = SPI_SAVE;
                end
            end
            SPI_SAVE:  state_nxt = SPI_BACK;
            SPI_BACK:  state_nxt = ss_level ? SPI_RST : SPI_LOAD;
            SPI_RST: begin
                if (ss_level) begin
                    state_nxt = SPI_IDLE;  // Wait for SS high after reset
                end
            end
            default:   state_nxt = SPI_RST;
        endcase

        // SS release ends the frame from anywhere
        if (ss_rise && (state != SPI_IDLE)) begin
            state_nxt = SPI_RST;
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= SPI_RST;
            cmd_done     <= 1'b0;
            in_data      <= 1'b0;
            remaining    <= '0;
            frame_active <= 1'b0;
            err          <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            state      <= state_nxt;
            frame_done <= 1'b0;
            case (state)
                SPI_IDLE: begin
                    if (ss_fall) begin
                        err          <= 1'b0;  // Cleared by the next frame
                        frame_active <= 1'b1;
                        cmd_done     <= 1'b0;
                        in_data      <= 1'b0;
                        remaining    <= '0;
                    end
                end
                SPI_SAVE: begin
                    if (!cmd_done) begin
                        cmd_done <= 1'b1;
                        if (!rx_cmd.long_fmt) begin
                            in_data   <= 1'b1;  // Short format, one byte
                            remaining <= byte_cnt_t'(1);
                        end
                    end else if (!in_data) begin
                        in_data   <= 1'b1;
                        remaining <= rx_byte[4:0];  // Length byte
                    end else if (data_valid) begin
                        remaining <= remaining - 1'b1;
                    end
                end
                SPI_RST: begin
                    if (frame_active) begin  // Nothing to report after reset
                        frame_active <= 1'b0;
                        err          <= !frame_complete;
                        frame_done   <= frame_complete;
                    end
                end
                default: ;
            endcase
        end
    end

    // Command and running address
    always_ff @(posedge clk) begin
        if (state == SPI_SAVE) begin
            if (!cmd_done) begin
                cmd      <= rx_cmd;
                run_addr <= rx_cmd.addr;
            end else if (data_valid) begin
                run_addr <= run_addr + 1'b1;  // Wraps modulo 32
            end
        end
    end

endmodule

//--- logic/spi_reg_bank.sv
// Byte register bank
`timescale 1ns/10ps

module spi_reg_bank import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_wr_t   spi_wr,        // Write from the SPI side
    input  reg_wr_t   host_wr,       // Write from local logic
    input  reg_addr_t spi_rd_addr,
    output byte_t     spi_rd_data,
    input  reg_addr_t host_addr,
    output byte_t     host_rd_data
);

    byte_t regs [REG_COUNT];

    // One write per cycle, SPI side first
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (spi_wr.en) begin
            regs[spi_wr.addr] <= spi_wr.data;
        end else if (host_wr.en) begin
            regs[host_wr.addr] <= host_wr.data;  // Dropped on a collision
        end
    end

    // Independent read ports
    assign spi_rd_data  = regs[spi_rd_addr];
    assign host_rd_data = regs[host_addr];

endmodule

//--- logic/spi_reg_top.sv
// SPI slave with register bank
`timescale 1ns/10ps

module spi_reg_top import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      sclk,
    input  logic      ss,
    input  logic      mosi,
    output logic      miso,
    input  reg_addr_t host_addr,
    output byte_t     host_rd_data,
    input  reg_wr_t   host_wr,
    output logic      err,
    output logic      busy,
    output logic      frame_done
);

    // Synchronized pins
    logic sclk_rise;
    logic sclk_fall;
    logic ss_fall;
    logic ss_rise;
    logic ss_level;
    logic mosi_sync;

    // Shifter interface
    logic  load;
    byte_t tx_byte;
    byte_t rx_byte;
    logic  byte_done;

    // Bank access from the frame controller
    reg_wr_t   spi_wr;
    reg_addr_t spi_rd_addr;
    byte_t     spi_rd_data;

    sclk_edge_detect sclk_edge_detect_i (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .ss        (ss),
        .mosi      (mosi),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .ss_fall   (ss_fall),
        .ss_rise   (ss_rise),
        .ss_level  (ss_level),
        .mosi_sync (mosi_sync)
    );

    spi_shift_reg spi_shift_reg_i (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .tx_byte   (tx_byte),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .mosi      (mosi_sync),
        .miso      (miso),
        .rx_byte   (rx_byte),
        .byte_done (byte_done)
    );

    spi_comm spi_comm_i (
        .clk         (clk),
        .rst         (rst),
        .ss_fall     (ss_fall),
        .ss_rise     (ss_rise),
        .ss_level    (ss_level),
        .byte_done   (byte_done),
        .rx_byte     (rx_byte),
        .load        (load),
        .tx_byte     (tx_byte),
        .spi_wr      (spi_wr),
        .spi_rd_addr (spi_rd_addr),
        .spi_rd_data (spi_rd_data),
        .err         (err),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    spi_reg_bank spi_reg_bank_i (
        .clk          (clk),
        .rst          (rst),
        .spi_wr       (spi_wr),
        .host_wr      (host_wr),
        .spi_rd_addr  (spi_rd_addr),
        .spi_rd_data  (spi_rd_data),
        .host_addr    (host_addr),
        .host_rd_data (host_rd_data)
    );

endmodule

//--- tests/tb_spi_reg_top.sv
// Testbench for the SPI register slave
`timescale 1ns/10ps

module tb_spi_reg_top import spi_pkg::*; ();

    localparam int HALF       = 8;   // SCLK half period in clk cycles
    localparam int CLK_NS     = 10;
    localparam int SPI_BYTES  = 31;  // Bytes shifted over all tests
    localparam int TIMEOUT_NS = SPI_BYTES * 20 * HALF * CLK_NS + 20000;

    logic      clk;
    logic      rst;
    logic      sclk;
    logic      ss;
    logic      mosi;
    logic      miso;
    reg_addr_t host_addr;
    byte_t     host_rd_data;
    reg_wr_t   host_wr;
    logic      err;
    logic      busy;
    logic      frame_done;

    byte_t     model [REG_COUNT];  // Expected bank contents
    byte_t     tx_q [$];           // Bytes of the next frame
    byte_t     rx_q [$];           // MISO bytes seen in that frame
    integer    seed = 32'he32c;
    int        err_cnt = 0;
    int        check_cnt = 0;
    int        test_cnt = 0;
    int        done_cnt = 0;       // frame_done pulses so far
    logic      err_at_start;       // err shortly after SS fall
    logic      busy_at_start;      // busy shortly after SS fall
    int        hit_idx;            // Byte that gets a colliding host write or -1
    reg_addr_t hit_addr;
    byte_t     hit_data;

    spi_reg_top spi_reg_top_i (
        .clk          (clk),
        .rst          (rst),
        .sclk         (sclk),
        .ss           (ss),
        .mosi         (mosi),
        .miso         (miso),
        .host_addr    (host_addr),
        .host_rd_data (host_rd_data),
        .host_wr      (host_wr),
        .err          (err),
        .busy         (busy),
        .frame_done   (frame_done)
    );

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (frame_done === 1'b1) done_cnt++;  // Pulse is stable at negedge
    end

    task automatic wait_clks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic check(input string sig, input logic [31:0] act, input logic [31:0] want);
        check_cnt++;
        if (act !== want) begin
            err_cnt++;
            $display("FAIL %0t ns %s: got %h, expected %h", $time, sig, act, want);
        end
    endtask

    task automatic end_test(input string name, input int e0);
        test_cnt++;
        $display("test %-14s finished with %0d errors", name, err_cnt - e0);
    endtask

    // Mode 1 master driving MOSI on rise and sampling MISO on fall
    task automatic xfer_byte(input byte_t tx, input int bits, input bit hit, output byte_t rx);
        rx = '0;
        for (int i = 7; i >= 8 - bits; i--) begin
            sclk = 1'b1;
            mosi = tx[i];
            wait_clks(HALF);
            sclk = 1'b0;
            rx[i] = miso;
            if (i == 0 && hit) begin
                // Edge delay of 3 and byte_done put SAVE after the 5th edge
                wait_clks(5);
                host_wr = '{en: 1'b1, addr: hit_addr, data: hit_data};
                wait_clks(1);
                host_wr = '0;
                wait_clks(HALF - 6);
            end else begin
                wait_clks(HALF);
            end
        end
    endtask

    // Last byte may be cut short to abort mid-byte
    task automatic run_frame(input int last_bits);
        byte_t rx;
        int    bits;
        rx_q.delete();
        ss = 1'b0;
        wait_clks(HALF);
        err_at_start  = err;
        busy_at_start = busy;
        foreach (tx_q[i]) begin
            bits = (i == tx_q.size() - 1) ? last_bits : 8;
            xfer_byte(tx_q[i], bits, i == hit_idx, rx);
            rx_q.push_back(rx);
        end
        ss = 1'b1;
        wait_clks(2 * HALF);  // Room for the frame end pulse
    endtask

    task automatic read_host(input reg_addr_t a, output byte_t d);
        host_addr = a;
        wait_clks(1);
        d = host_rd_data;
    endtask

    task automatic host_write(input reg_addr_t a, input byte_t d);
        host_wr = '{en: 1'b1, addr: a, data: d};
        wait_clks(1);
        host_wr = '0;
        model[a] = d;
    endtask

    task automatic compare_bank();
        byte_t d;
        for (int a = 0; a < REG_COUNT; a++) begin
            read_host(reg_addr_t'(a), d);
            check($sformatf("reg[%0d]", a), d, model[a]);
        end
    endtask

    task automatic reset_test();
        int e0;
        e0 = err_cnt;
        check("err", err, 0);
        check("busy", busy, 0);
        check("frame_done", frame_done, 0);
        check("miso", miso, 0);
        compare_bank();  // Model starts all zero
        end_test("reset", e0);
    endtask

    task automatic short_rw_test();
        int    e0;
        int    d0;
        byte_t d;
        byte_t rd;
        e0 = err_cnt;
        d0 = done_cnt;
        d = $random(seed);
        tx_q.delete();
        tx_q.push_back(8'h03);  // Short write to address 3
        tx_q.push_back(d);
        run_frame(8);
        model[3] = d;
        check("busy at frame start", busy_at_start, 1);
        check("busy", busy, 0);
        check("miso cmd", rx_q[0], IDLE_PATTERN);
        read_host(5'd3, rd);
        check("reg[3]", rd, d);
        check("frame_done count", done_cnt - d0, 1);
        check("err", err, 0);
        tx_q.delete();
        tx_q.push_back(8'h43);  // Short read of address 3
        tx_q.push_back(8'h00);
        run_frame(8);
        check("miso cmd", rx_q[0], IDLE_PATTERN);
        check("miso data", rx_q[1], d);
        check("frame_done count", done_cnt - d0, 2);
        check("err", err, 0);
        end_test("short r/w", e0);
    endtask

    task automatic burst_write_test();
        int    e0;
        int    d0;
        byte_t d;
        e0 = err_cnt;
        d0 = done_cnt;
        tx_q.delete();
        tx_q.push_back(8'h9E);  // Long write from 30
        tx_q.push_back(8'h05);
        for (int i = 0; i < 7; i++) begin
            d = $random(seed);
            tx_q.push_back(d);
            if (i < 5) model[reg_addr_t'(30 + i)] = d;  // Last two are extra
        end
        run_frame(8);
        check("miso extra 0", rx_q[7], 0);
        check("miso extra 1", rx_q[8], 0);
        check("frame_done count", done_cnt - d0, 1);
        check("err", err, 0);
        compare_bank();
        end_test("burst write", e0);
    endtask

    task automatic burst_read_test();
        int e0;
        int d0;
        e0 = err_cnt;
        d0 = done_cnt;
        for (int i = 10; i < 14; i++) begin
            host_write(reg_addr_t'(i), $random(seed));
        end
        tx_q.delete();
        tx_q.push_back(8'hCA);  // Long read from 10
        tx_q.push_back(8'h04);
        repeat (6) tx_q.push_back(8'h00);
        run_frame(8);
        check("miso cmd", rx_q[0], IDLE_PATTERN);
        check("miso length", rx_q[1], IDLE_PATTERN);
        for (int i = 0; i < 4; i++) begin
            check($sformatf("miso data %0d", i), rx_q[2 + i], model[10 + i]);
        end
        check("miso extra 0", rx_q[6], 0);
        check("miso extra 1", rx_q[7], 0);
        check("frame_done count", done_cnt - d0, 1);
        check("err", err, 0);
        end_test("burst read", e0);
    endtask

    task automatic abort_test();
        int    e0;
        int    d0;
        byte_t d;
        e0 = err_cnt;
        d0 = done_cnt;
        tx_q.delete();
        tx_q.push_back(8'h05);  // Short write with data cut after 3 bits
        tx_q.push_back(8'hFF);
        run_frame(3);
        check("err", err, 1);
        check("frame_done count", done_cnt - d0, 0);
        tx_q.delete();
        tx_q.push_back(8'h88);  // Long write of 3 with only 2 sent
        tx_q.push_back(8'h03);
        for (int i = 0; i < 2; i++) begin
            d = $random(seed);
            tx_q.push_back(d);
            model[8 + i] = d;
        end
        run_frame(8);
        check("err at frame start", err_at_start, 0);
        check("err", err, 1);
        check("frame_done count", done_cnt - d0, 0);
        compare_bank();
        d = $random(seed);
        tx_q.delete();
        tx_q.push_back(8'h0C);
        tx_q.push_back(d);
        run_frame(8);
        model[12] = d;
        check("err at frame start", err_at_start, 0);
        check("err", err, 0);
        check("frame_done count", done_cnt - d0, 1);
        compare_bank();
        end_test("abort", e0);
    endtask

    task automatic priority_test();
        int    e0;
        int    d0;
        byte_t s;
        e0 = err_cnt;
        d0 = done_cnt;
        s = $random(seed);
        host_addr = 5'd20;
        host_wr = '{en: 1'b1, addr: 5'd20, data: s};
        #1;
        check("host_rd_data before edge", host_rd_data, model[20]);
        wait_clks(1);
        host_wr = '0;
        model[20] = s;
        check("host_rd_data after edge", host_rd_data, s);
        hit_idx  = 1;  // Host write lands on the data byte SAVE
        hit_addr = 5'd21;
        hit_data = ~s;
        tx_q.delete();
        tx_q.push_back(8'h15);
        tx_q.push_back(s);
        run_frame(8);
        hit_idx = -1;
        model[21] = s;  // SPI side wins
        check("frame_done count", done_cnt - d0, 1);
        compare_bank();
        end_test("priority", e0);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        sclk      = 1'b0;
        ss        = 1'b1;
        mosi      = 1'b0;
        host_addr = '0;
        host_wr   = '0;
        hit_idx   = -1;
        for (int i = 0; i < REG_COUNT; i++) model[i] = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        wait_clks(4);
        reset_test();
        short_rw_test();
        burst_write_test();
        burst_read_test();
        abort_test();
        priority_test();
        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

endmodule

//--- filelist.f
logic/spi_pkg.sv
logic/sclk_edge_detect.sv
logic/spi_shift_reg.sv
logic/spi_comm.sv
logic/spi_reg_bank.sv
logic/spi_reg_top.sv
tests/tb_spi_reg_top.sv

//--- Bender.yml
package:
  name: spi_reg_slave

sources:
  - logic/spi_pkg.sv
  - logic/sclk_edge_detect.sv
  - logic/spi_shift_reg.sv
  - logic/spi_comm.sv
  - logic/spi_reg_bank.sv
  - logic/spi_reg_top.sv
  - target: test
    files:
      - tests/tb_spi_reg_top.sv
